// ==== flist.f ====
+incdir+.
road_pkg.sv
road_ctrl_regs.sv
road_line_ram.sv
road_line_fetch.sv
road_layer.sv
road_mixer.sv
road_top.sv
road_checker.sv
tb_road.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_road -o sim_tb_road

out=$(./obj_dir/sim_tb_road)
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

// ==== tb_road.sv ====
// Random stimulus from a fixed seed and ROM responders limited to 3 clocks of latency
`timescale 1ns/100ps
`default_nettype none

module tb_road import road_pkg::*; ();

    logic           clk;
    logic           rst;
    logic           pxl_cen;
    logic     [8:0] v;
    logic           vint;
    logic           hs;
    road_cpu_addr_t cpu_addr;
    road_word_t     cpu_dout;
    road_word_t     cpu_din;
    logic     [1:0] cpu_dswn;
    logic           road_cs;
    logic           io_cs;
    road_rom_addr_t rom0_addr;
    road_word_t     rom0_data;
    logic           rom0_cs;
    logic           rom0_ok;
    road_rom_addr_t rom1_addr;
    road_word_t     rom1_data;
    logic           rom1_cs;
    logic           rom1_ok;
    road_code_t     pxl;

    integer      seed;
    int          errors;
    int          checks;
    int          tests;
    int          wait0;
    int          wait1;
    // Model of both banks, indexed by bank then CPU word address
    road_word_t  mem_model [2][2048];
    logic        bank_model;
    logic        armed_model;
    road_mode_t  mode_model;

    road_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .v         (v),
        .vint      (vint),
        .hs        (hs),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .cpu_din   (cpu_din),
        .cpu_dswn  (cpu_dswn),
        .road_cs   (road_cs),
        .io_cs     (io_cs),
        .rom0_addr (rom0_addr),
        .rom0_data (rom0_data),
        .rom0_cs   (rom0_cs),
        .rom0_ok   (rom0_ok),
        .rom1_addr (rom1_addr),
        .rom1_data (rom1_data),
        .rom1_cs   (rom1_cs),
        .rom1_ok   (rom1_ok),
        .pxl       (pxl)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ======================================================================
    // Helpers and reference model
    // ======================================================================

    function automatic int unsigned rnd(input int unsigned n);
        rnd = $unsigned($random(seed)) % n;
    endfunction

    // Fixed ROM content, a hash of the word address
    function automatic road_word_t rom_word(input road_rom_addr_t a);
        road_word_t x;
        x = {2'b00, a};
        rom_word = (x * 16'h9e37) ^ {x[7:0], x[15:8]} ^ 16'h3c5a;
    endfunction

    function automatic road_pxl_t layer_pixel(input road_field_t idx, input road_field_t scr,
                                              input int n);
        road_field_t h;
        road_word_t  w;
        int          b;
        h = scr + road_field_t'(n);
        if (idx[11] || (h[11:9] != 3'd3)) begin
            return 2'b11;
        end
        w = rom_word({idx[8:1], h[8:3]});
        b = int'(h[2:0]);
        return {w[15 - b], w[7 - b]};
    endfunction

    function automatic road_code_t expected_code(input road_mode_t m, input road_pxl_t p0,
                                                 input road_pxl_t p1, input road_field_t c);
        road_code_t c0;
        road_code_t c1;
        c0 = {1'b0, c[4:0], p0};
        c1 = {1'b1, c[9:5], p1};
        case (m)
            2'd0: return (p0 != 2'b11) ? c0 : ((p1 != 2'b11) ? c1 : 8'hff);
            2'd1: return (p1 != 2'b11) ? c1 : ((p0 != 2'b11) ? c0 : 8'hff);
            2'd2: return (p0 != 2'b11) ? c0 : 8'hff;
            default: return (p1 != 2'b11) ? c1 : 8'hff;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %s ok", name);
        end else begin
            $display("test %s FAILED with %0d errors", name, errors - err_before);
        end
    endtask

    // ======================================================================
    // ROM responders, random latency of 1 to 3 clocks
    // ======================================================================

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rom0_ok   <= 1'b0;
            rom0_data <= '0;
            wait0     <= 1;
        end else begin
            rom0_ok <= 1'b0;
            if (rom0_cs && !rom0_ok) begin
                if (wait0 <= 1) begin
                    rom0_ok   <= 1'b1;
                    rom0_data <= rom_word(rom0_addr);
                    wait0     <= 1 + int'(rnd(3));
                end else begin
                    wait0 <= wait0 - 1;
                end
            end
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rom1_ok   <= 1'b0;
            rom1_data <= '0;
            wait1     <= 1;
        end else begin
            rom1_ok <= 1'b0;
            if (rom1_cs && !rom1_ok) begin
                if (wait1 <= 1) begin
                    rom1_ok   <= 1'b1;
                    rom1_data <= rom_word(rom1_addr);
                    wait1     <= 1 + int'(rnd(3));
                end else begin
                    wait1 <= wait1 - 1;
                end
            end
        end
    end

    // ======================================================================
    // CPU bus tasks
    // ======================================================================

    task automatic cpu_write(input road_cpu_addr_t a, input road_word_t d, input logic [1:0] s);
        @(posedge clk);
        road_cs  <= 1'b1;
        cpu_addr <= a;
        cpu_dout <= d;
        cpu_dswn <= s;
        @(posedge clk);
        road_cs  <= 1'b0;
        cpu_dswn <= 2'b11;
        if (!s[0]) begin
            mem_model[bank_model][a][7:0] = d[7:0];
        end
        if (!s[1]) begin
            mem_model[bank_model][a][15:8] = d[15:8];
        end
    endtask

    task automatic cpu_read(input road_cpu_addr_t a, input string name);
        @(posedge clk);
        cpu_addr <= a;
        @(posedge clk);
        @(negedge clk);
        check_val(name, mem_model[bank_model][a], cpu_din);
    endtask

    task automatic set_mode(input road_mode_t m);
        @(posedge clk);
        io_cs    <= 1'b1;
        cpu_dswn <= 2'b10;
        cpu_dout <= {14'd0, m};
        @(posedge clk);
        io_cs    <= 1'b0;
        cpu_dswn <= 2'b11;
        mode_model = m;
    endtask

    task automatic arm_swap();
        @(posedge clk);
        io_cs    <= 1'b1;
        cpu_dswn <= 2'b11;
        @(posedge clk);
        io_cs <= 1'b0;
        armed_model = 1'b1;
    endtask

    task automatic pulse_vint();
        @(posedge clk);
        vint <= 1'b1;
        @(posedge clk);
        vint <= 1'b0;
        if (armed_model) begin
            bank_model  = ~bank_model;
            armed_model = 1'b0;
        end
    endtask

    // ======================================================================
    // Line tasks
    // ======================================================================

    function automatic road_field_t pick_scroll(input bit in_win);
        int unsigned p;
        p = in_win ? 3 : rnd(4);
        case (p)
            0: return road_field_t'(12'h5f0 + rnd(16));
            1: return road_field_t'(12'h7f0 + rnd(8));
            2: return road_field_t'(rnd(4096));
            default: return road_field_t'(12'h600 + rnd(480));
        endcase
    endfunction

    task automatic prep_line(input logic [7:0] line, input bit hide0, input bit hide1,
                             input bit in_win);
        road_field_t f [5];
        f[0] = road_field_t'(rnd(4096));
        f[1] = road_field_t'(rnd(4096));
        f[0][11] = hide0;
        f[1][11] = hide1;
        f[2] = pick_scroll(in_win);
        f[3] = pick_scroll(in_win);
        f[4] = road_field_t'(rnd(4096));
        for (int s = 0; s < 5; s++) begin
            cpu_write({line, 3'(s)}, {4'(rnd(16)), f[s]}, 2'b00);
        end
    endtask

    task automatic run_line(input logic [7:0] line, input int npix, input string name);
        road_field_t f [5];
        logic        eb;
        int          t;
        road_pxl_t   p0;
        road_pxl_t   p1;
        eb = ~bank_model;
        for (int s = 0; s < 5; s++) begin
            f[s] = mem_model[eb][{line, 3'(s)}][11:0];
        end
        @(posedge clk);
        v  <= {1'b0, line};
        hs <= 1'b1;
        repeat (10) @(posedge clk);
        hs <= 1'b0;
        repeat (12) @(posedge clk);
        // First word should be prefetched by now
        t = 0;
        @(negedge clk);
        while ((rom0_cs || rom1_cs) && (t < 8)) begin
            @(negedge clk);
            t++;
        end
        if (rom0_cs || rom1_cs) begin
            errors++;
            $display("%s: ROM prefetch did not finish after hs fell", name);
        end
        for (int n = 0; n < npix; n++) begin
            @(posedge clk);
            pxl_cen <= 1'b1;
            @(posedge clk);
            pxl_cen <= 1'b0;
            @(negedge clk);
            p0 = layer_pixel(f[0], f[2], n);
            p1 = layer_pixel(f[1], f[3], n);
            check_val(name, {8'h00, expected_code(mode_model, p0, p1, f[4])}, {8'h00, pxl});
            repeat (2) @(posedge clk);
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        road_cpu_addr_t addrs [48];
        int             e0;
        seed        = 32'h3765;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        bank_model  = 1'b0;
        armed_model = 1'b0;
        mode_model  = 2'd0;
        rst         = 1'b1;
        pxl_cen     = 1'b0;
        v           = '0;
        vint        = 1'b0;
        hs          = 1'b0;
        cpu_addr    = '0;
        cpu_dout    = '0;
        cpu_dswn    = 2'b11;
        road_cs     = 1'b0;
        io_cs       = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        e0 = errors;
        for (int i = 0; i < 48; i++) begin
            addrs[i] = road_cpu_addr_t'(rnd(2048));
            cpu_write(addrs[i], road_word_t'(rnd(65536)), 2'b00);
            cpu_write(addrs[i], road_word_t'(rnd(65536)), 2'(rnd(4)));
        end
        for (int i = 0; i < 48; i++) begin
            cpu_read(addrs[i], "cpu_readback");
        end
        finish_test("cpu_readback", e0);

        e0 = errors;
        cpu_write(11'h155, 16'ha5c3, 2'b00);
        pulse_vint();
        cpu_read(11'h155, "bank_swap");
        arm_swap();
        pulse_vint();
        cpu_write(11'h155, 16'h5a3c, 2'b00);
        arm_swap();
        pulse_vint();
        cpu_read(11'h155, "bank_swap");
        arm_swap();
        pulse_vint();
        cpu_read(11'h155, "bank_swap");
        finish_test("bank_swap", e0);

        e0 = errors;
        prep_line(8'd10, 1'b0, 1'b0, 1'b0);
        prep_line(8'd11, 1'b0, 1'b0, 1'b1);
        prep_line(8'd12, 1'b1, 1'b1, 1'b1);
        arm_swap();
        pulse_vint();
        for (int m = 2; m < 4; m++) begin
            set_mode(road_mode_t'(m));
            for (int l = 10; l < 13; l++) begin
                run_line(8'(l), 24, "single_layer");
            end
        end
        finish_test("single_layer", e0);

        e0 = errors;
        prep_line(8'd20, 1'b0, 1'b0, 1'b1);
        prep_line(8'd21, 1'b0, 1'b0, 1'b0);
        prep_line(8'd22, 1'b1, 1'b0, 1'b1);
        arm_swap();
        pulse_vint();
        for (int m = 0; m < 2; m++) begin
            set_mode(road_mode_t'(m));
            for (int l = 20; l < 23; l++) begin
                run_line(8'(l), 24, "priority");
            end
        end
        finish_test("priority", e0);

        e0 = errors;
        set_mode(2'd0);
        for (int l = 40; l < 43; l++) begin
            prep_line(8'(l), 1'b0, 1'b0, 1'b1);
        end
        arm_swap();
        pulse_vint();
        for (int l = 40; l < 43; l++) begin
            run_line(8'(l), 48, "rom_latency");
        end
        finish_test("rom_latency", e0);

        e0 = errors;
        prep_line(8'd3, 1'b0, 1'b0, 1'b1);
        prep_line(8'd200, 1'b0, 1'b0, 1'b1);
        prep_line(8'd77, 1'b0, 1'b0, 1'b0);
        arm_swap();
        pulse_vint();
        // New CPU bank contents must not reach the engine
        prep_line(8'd200, 1'b0, 1'b0, 1'b1);
        run_line(8'd200, 24, "per_line");
        run_line(8'd3, 24, "per_line");
        run_line(8'd77, 24, "per_line");
        finish_test("per_line", e0);

        errors += int'(dut_i.chk_i.errors);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== road_checker.sv ====
// Bound into road_top and only valid while the ROM ports keep rom_ok to cycles with rom_cs high
`timescale 1ns/100ps
`default_nettype none

module road_checker import road_pkg::*; (
    input wire            clk,
    input wire            rst,
    input wire            hs,
    input wire            vint,
    input wire            bank_sel,
    input wire            rom0_cs,
    input wire            rom0_ok,
    input road_rom_addr_t rom0_addr,
    input wire            rom1_cs,
    input wire            rom1_ok,
    input road_rom_addr_t rom1_addr
);

    int unsigned errors = 0;

    // ======================================================================
    // ROM port rules
    // ======================================================================

    rom_idle_in_hs: assert property (@(posedge clk) disable iff (rst)
        hs |-> !rom0_cs && !rom1_cs)
        else begin
            $error("ROM request while hs is high");
            errors++;
        end

    rom0_addr_stable: assert property (@(posedge clk) disable iff (rst)
        rom0_cs && !rom0_ok |=> !rom0_cs || (rom0_addr == $past(rom0_addr)))
        else begin
            $error("rom0_addr moved while waiting for rom0_ok");
            errors++;
        end

    rom1_addr_stable: assert property (@(posedge clk) disable iff (rst)
        rom1_cs && !rom1_ok |=> !rom1_cs || (rom1_addr == $past(rom1_addr)))
        else begin
            $error("rom1_addr moved while waiting for rom1_ok");
            errors++;
        end

    rom_idle_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !rom0_cs && !rom1_cs)
        else begin
            $error("ROM request in the first clock after reset");
            errors++;
        end

    // Bank flips only on a clock with vint high
    bank_on_vint: assert property (@(posedge clk) disable iff (rst)
        (bank_sel != $past(bank_sel)) |-> $past(vint))
        else begin
            $error("bank_sel changed without vint");
            errors++;
        end

endmodule

bind road_top road_checker chk_i (
    .clk       (clk),
    .rst       (rst),
    .hs        (hs),
    .vint      (vint),
    .bank_sel  (bank_sel),
    .rom0_cs   (rom0_cs),
    .rom0_ok   (rom0_ok),
    .rom0_addr (rom0_addr),
    .rom1_cs   (rom1_cs),
    .rom1_ok   (rom1_ok),
    .rom1_addr (rom1_addr)
);

`default_nettype wire

// ==== road_top.sv ====
// Single clock domain and the ROM ports expect rom_ok only while their rom_cs is high
`timescale 1ns/100ps
`default_nettype none

module road_top import road_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire            pxl_cen,
    input  wire      [8:0] v,
    input  wire            vint,
    input  wire            hs,

    input  road_cpu_addr_t cpu_addr,
    input  road_word_t     cpu_dout,
    output road_word_t     cpu_din,
    input  wire      [1:0] cpu_dswn,
    input  wire            road_cs,
    input  wire            io_cs,

    output road_rom_addr_t rom0_addr,
    input  road_word_t     rom0_data,
    output wire            rom0_cs,
    input  wire            rom0_ok,

    output road_rom_addr_t rom1_addr,
    input  road_word_t     rom1_data,
    output wire            rom1_cs,
    input  wire            rom1_ok,

    output road_code_t     pxl
);

    road_mode_t     mode;
    wire            bank_sel;
    road_cpu_addr_t eng_addr;
    road_word_t     eng_data;
    road_field_t    idx0;
    road_field_t    idx1;
    road_field_t    scr0;
    road_field_t    scr1;
    road_field_t    col;
    road_pxl_t      pxl0;
    road_pxl_t      pxl1;

    // ======================================================================
    // CPU side
    // ======================================================================

    road_ctrl_regs ctrl_i (
        .clk      (clk),
        .rst      (rst),
        .io_cs    (io_cs),
        .cpu_dswn (cpu_dswn),
        .cpu_dout (cpu_dout),
        .vint     (vint),
        .mode     (mode),
        .bank_sel (bank_sel)
    );

    road_line_ram ram_i (
        .clk      (clk),
        .road_cs  (road_cs),
        .cpu_dswn (cpu_dswn),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .bank_sel (bank_sel),
        .eng_addr (eng_addr),
        .cpu_din  (cpu_din),
        .eng_data (eng_data)
    );

    // ======================================================================
    // Engine side
    // ======================================================================

    road_line_fetch fetch_i (
        .clk      (clk),
        .rst      (rst),
        .hs       (hs),
        .v        (v),
        .eng_data (eng_data),
        .eng_addr (eng_addr),
        .idx0     (idx0),
        .idx1     (idx1),
        .scr0     (scr0),
        .scr1     (scr1),
        .col      (col)
    );

    road_layer layer0_i (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .hs       (hs),
        .idx      (idx0),
        .scr      (scr0),
        .rom_data (rom0_data),
        .rom_ok   (rom0_ok),
        .rom_addr (rom0_addr),
        .rom_cs   (rom0_cs),
        .pxl      (pxl0)
    );

    road_layer layer1_i (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .hs       (hs),
        .idx      (idx1),
        .scr      (scr1),
        .rom_data (rom1_data),
        .rom_ok   (rom1_ok),
        .rom_addr (rom1_addr),
        .rom_cs   (rom1_cs),
        .pxl      (pxl1)
    );

    road_mixer mixer_i (
        .mode (mode),
        .pxl0 (pxl0),
        .pxl1 (pxl1),
        .col  (col),
        .code (pxl)
    );

endmodule

`default_nettype wire

// ==== road_mixer.sv ====
// Purely combinational so the code follows the layer pixels registered on pxl_cen
`timescale 1ns/100ps
`default_nettype none

module road_mixer import road_pkg::*; (
    input  road_mode_t  mode,
    input  road_pxl_t   pxl0,
    input  road_pxl_t   pxl1,
    input  road_field_t col,
    output road_code_t  code
);

    logic      front;
    logic      back_en;
    road_pxl_t front_pxl;
    road_pxl_t back_pxl;
    logic      sel;
    logic      hit;

    // Mode bit 0 picks the front layer, bit 1 hides the other one
    assign front     = mode[0];
    assign back_en   = !mode[1];
    assign front_pxl = front ? pxl1 : pxl0;
    assign back_pxl  = front ? pxl0 : pxl1;

    always_comb begin
        sel = front;
        hit = 1'b0;
        if (front_pxl != 2'b11) begin
            hit = 1'b1;
        end else if (back_en && (back_pxl != 2'b11)) begin
            sel = ~front;
            hit = 1'b1;
        end
    end

    // Layer bit, 5-bit colour of that layer, then the pixel
    always_comb begin
        if (!hit) begin
            code = 8'hff;
        end else if (sel) begin
            code = {1'b1, col[9:5], pxl1};
        end else begin
            code = {1'b0, col[4:0], pxl0};
        end
    end

endmodule

`default_nettype wire

// ==== road_layer.sv ====
// Needs ROM latency of 3 clocks or less, pxl_cen at most 1 in 4 and 12 clocks after hs falls
`timescale 1ns/100ps
`default_nettype none

module road_layer import road_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire            pxl_cen,
    input  wire            hs,
    input  road_field_t    idx,
    input  road_field_t    scr,
    input  road_word_t     rom_data,
    input  wire            rom_ok,
    output road_rom_addr_t rom_addr,
    output logic           rom_cs,
    output road_pxl_t      pxl
);

    layer_state_t state;
    logic         hs_l;
    logic         first;
    road_field_t  hpos;
    road_field_t  idx_l;
    logic [5:0]   req_grp;
    // Group that the next group start will need
    logic [5:0]   nxt_grp;
    road_word_t   buf_word;
    road_word_t   cur_word;
    logic         cur_ok;
    logic         live;
    logic         new_grp;
    logic         consume;
    logic         fresh;
    logic         keep;
    logic         win;
    road_word_t   word;
    logic         word_ok;
    road_word_t   shifted;

    assign live    = !hs && !hs_l;
    assign new_grp = first || (hpos[2:0] == 3'd0);
    assign consume = live && pxl_cen && new_grp;
    // Wanted word arriving in this clock
    assign fresh   = live && (state == layer_request) && rom_ok && (req_grp == nxt_grp);
    // Word is kept only if it is still the one wanted next
    assign keep    = fresh && !consume;

    assign rom_cs   = (state == layer_request) && !hs;
    assign rom_addr = {idx_l[8:1], req_grp};

    // ======================================================================
    // Pixel extraction
    // ======================================================================

    assign win     = !idx_l[11] && (hpos[11:9] == 3'd3);
    // At a group start the prefetched word takes over, or the word arriving right now
    assign word    = new_grp ? (fresh ? rom_data : buf_word) : cur_word;
    assign word_ok = new_grp ? ((state == layer_holding) || fresh) : cur_ok;
    assign shifted = word << hpos[2:0];

    always_ff @(posedge clk) begin
        if (keep) begin
            buf_word <= rom_data;
        end
        if (consume) begin
            cur_word <= word;
        end
    end

    // ======================================================================
    // Scroll counter and ROM request FSM
    // ======================================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= layer_idle;
            hs_l    <= 1'b0;
            first   <= 1'b0;
            hpos    <= '0;
            idx_l   <= '0;
            req_grp <= '0;
            nxt_grp <= '0;
            cur_ok  <= 1'b0;
            pxl     <= 2'b11;
        end else begin
            hs_l <= hs;
            if (hs) begin
                state <= layer_idle;
                pxl   <= 2'b11;
            end else if (hs_l) begin
                // Falling edge of hs starts the line
                hpos    <= scr;
                idx_l   <= idx;
                req_grp <= scr[8:3];
                nxt_grp <= scr[8:3];
                first   <= 1'b1;
                cur_ok  <= 1'b0;
                state   <= layer_request;
            end else begin
                if (pxl_cen) begin
                    hpos  <= hpos + 1'b1;
                    first <= 1'b0;
                    pxl   <= (win && word_ok) ? {shifted[15], shifted[7]} : 2'b11;
                    if (new_grp) begin
                        cur_ok  <= word_ok;
                        nxt_grp <= nxt_grp + 6'd1;
                    end
                end
                case (state)
                    layer_request: begin
                        if (rom_ok) begin
                            if (keep) begin
                                state <= layer_holding;
                            end else begin
                                // Word used at once or late, then the next needed group asked for
                                req_grp <= consume ? nxt_grp + 6'd1 : nxt_grp;
                            end
                        end
                    end
                    layer_holding: begin
                        if (consume) begin
                            req_grp <= nxt_grp + 6'd1;
                            state   <= layer_request;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== road_line_fetch.sv ====
// Fields update within 7 clocks of the hs rise and a new hs rise restarts a fetch in progress
`timescale 1ns/100ps
`default_nettype none
`include "road_settings.svh"

module road_line_fetch import road_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire            hs,
    input  wire      [8:0] v,
    input  road_word_t     eng_data,
    output road_cpu_addr_t eng_addr,
    output road_field_t    idx0,
    output road_field_t    idx1,
    output road_field_t    scr0,
    output road_field_t    scr1,
    output road_field_t    col
);

    localparam int SLOT_W = $clog2(`ROAD_ENTRY_WORDS);
    localparam int LINE_W = $clog2(`ROAD_LINES);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`ROAD_FETCH_WORDS - 1);

    fetch_state_t      state;
    logic              hs_l;
    logic [LINE_W-1:0] line;
    logic [SLOT_W-1:0] slot;
    // Slot whose word the RAM returns in the current clock
    logic [SLOT_W-1:0] rd_slot;
    logic              rd_vld;

    assign eng_addr = {line, slot};

    // ======================================================================
    // Address sequencer
    // ======================================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= fetch_idle;
            hs_l    <= 1'b0;
            line    <= '0;
            slot    <= '0;
            rd_slot <= '0;
            rd_vld  <= 1'b0;
        end else begin
            hs_l    <= hs;
            rd_slot <= slot;
            rd_vld  <= (state == fetch_reading);
            if (hs && !hs_l) begin
                line  <= v[LINE_W-1:0];
                slot  <= '0;
                state <= fetch_reading;
            end else begin
                case (state)
                    fetch_reading: begin
                        if (slot == LAST_SLOT) begin
                            state <= fetch_done;
                        end else begin
                            slot <= slot + 1'b1;
                        end
                    end
                    // Last word is captured here
                    fetch_done: state <= fetch_idle;
                    default: ;
                endcase
            end
        end
    end

    // ======================================================================
    // Parameter capture, one clock behind the address
    // ======================================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx0 <= '0;
            idx1 <= '0;
            scr0 <= '0;
            scr1 <= '0;
            col  <= '0;
        end else if (rd_vld) begin
            case (rd_slot)
                3'd0: idx0 <= eng_data[11:0];
                3'd1: idx1 <= eng_data[11:0];
                3'd2: scr0 <= eng_data[11:0];
                3'd3: scr1 <= eng_data[11:0];
                3'd4: col  <= eng_data[11:0];
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== road_line_ram.sv ====
// No read-during-write bypass so a CPU read of a word written in the same clock returns old data
`timescale 1ns/100ps
`default_nettype none
`include "road_settings.svh"

module road_line_ram import road_pkg::*; (
    input  wire            clk,
    input  wire            road_cs,
    input  wire      [1:0] cpu_dswn,
    input  road_cpu_addr_t cpu_addr,
    input  road_word_t     cpu_dout,
    input  wire            bank_sel,
    input  road_cpu_addr_t eng_addr,
    output road_word_t     cpu_din,
    output road_word_t     eng_data
);

    // Two banks back to back, bank number in the top address bit
    localparam int DEPTH = 2 * `ROAD_LINES * `ROAD_ENTRY_WORDS;
    localparam int AW    = $clog2(DEPTH);

    logic [7:0]    mem_lo [DEPTH];
    logic [7:0]    mem_hi [DEPTH];
    logic [AW-1:0] cpu_a;
    logic [AW-1:0] eng_a;
    logic          we_lo;
    logic          we_hi;

    // CPU works on bank_sel while the engine reads the other bank
    assign cpu_a = {bank_sel, cpu_addr};
    assign eng_a = {~bank_sel, eng_addr};

    // Strobes are active low, bit 0 for the low byte
    assign we_lo = road_cs && !cpu_dswn[0];
    assign we_hi = road_cs && !cpu_dswn[1];

    // ======================================================================
    // Storage and registered read ports
    // ======================================================================

    always_ff @(posedge clk) begin
        if (we_lo) begin
            mem_lo[cpu_a] <= cpu_dout[7:0];
        end
        if (we_hi) begin
            mem_hi[cpu_a] <= cpu_dout[15:8];
        end
        // Read runs every clock so cpu_din follows the address
        cpu_din  <= {mem_hi[cpu_a], mem_lo[cpu_a]};
        eng_data <= {mem_hi[eng_a], mem_lo[eng_a]};
    end

endmodule

`default_nettype wire

// ==== road_ctrl_regs.sv ====
// Mode writes need the low byte strobe and an armed swap waits for the next clock with vint high
`timescale 1ns/100ps
`default_nettype none

module road_ctrl_regs import road_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        io_cs,
    input  wire  [1:0] cpu_dswn,
    input  road_word_t cpu_dout,
    input  wire        vint,
    output road_mode_t mode,
    output logic       bank_sel
);

    logic swap_armed;
    logic mode_we;
    logic swap_req;

    assign mode_we  = io_cs && !cpu_dswn[0];
    // Access with no byte strobe at all is the swap request
    assign swap_req = io_cs && (cpu_dswn == 2'b11);

    // ======================================================================
    // Priority mode register
    // ======================================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode <= '0;
        end else if (mode_we) begin
            mode <= road_mode_t'(cpu_dout[1:0]);
        end
    end

    // ======================================================================
    // Bank swap
    // ======================================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank_sel   <= 1'b0;
            swap_armed <= 1'b0;
        end else begin
            if (vint && swap_armed) begin
                bank_sel   <= ~bank_sel;
                swap_armed <= 1'b0;
            end else if (swap_req) begin
                swap_armed <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== road_pkg.sv ====
// Shared widths and FSM encodings. Only the low 12 bits of a line slot word carry data
`default_nettype none

package road_pkg;

    // Data words on the CPU bus, the line RAM and the ROM ports
    typedef logic [15:0] road_word_t;

    // Line number in bits 10:3 and slot in bits 2:0
    typedef logic [10:0] road_cpu_addr_t;

    // Index, scroll and colour parameters
    typedef logic [11:0] road_field_t;

    typedef logic [13:0] road_rom_addr_t;

    // Layer pixel where 3 is transparent
    typedef logic [1:0]  road_pxl_t;

    typedef logic [7:0]  road_code_t;
    typedef logic [1:0]  road_mode_t;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_reading,
        fetch_done
    } fetch_state_t;

    typedef enum logic [1:0] {
        layer_idle,
        layer_request,
        layer_holding
    } layer_state_t;

endpackage

`default_nettype wire

// ==== road_settings.svh ====
// Line RAM geometry is fixed by the board and the engine reads only the first five slots of an entry
`ifndef ROAD_SETTINGS_SVH
`define ROAD_SETTINGS_SVH

// ======================================================================
// Line parameter RAM geometry
// ======================================================================

// Lines held in one bank
`define ROAD_LINES 256

// Word slots reserved for each line entry
`define ROAD_ENTRY_WORDS 8

// ======================================================================
// Engine fetch
// ======================================================================

// Slots read at each horizontal sync
`define ROAD_FETCH_WORDS 5

`endif
